/* src/mbist_pkg.sv */
// Widths, test window, fixed March table and patterns for the MBIST controller
// ADDR_START must not exceed ADDR_END and both must fit in ADDR_WD bits
`default_nettype none

package mbist_pkg;

        localparam int ADDR_WD    = 9;
        localparam int DATA_WD    = 32;
        localparam int MASK_WD    = DATA_WD / 8;
        localparam int ERR_CNT_WD = 4;
        localparam int NUM_ELEM   = 4;
        localparam int NUM_PAT    = 2;

        typedef logic [ADDR_WD-1:0]    addr_t;
        typedef logic [DATA_WD-1:0]    data_t;
        typedef logic [MASK_WD-1:0]    mask_t;
        typedef logic [ERR_CNT_WD-1:0] err_cnt_t;
        typedef logic [1:0]            elem_t;

        localparam addr_t ADDR_START = 9'h000;
        localparam addr_t ADDR_END   = 9'h1FB;

        // Background patterns
        localparam data_t PAT_TABLE [NUM_PAT] = '{32'h0000_0000, 32'h5555_5555};

        // ------------------------------------------------------------
        // Operation code {read, write, invert}
        localparam logic [2:0] OP_NONE = 3'b000;
        localparam logic [2:0] OP_WT   = 3'b010;   // Write true
        localparam logic [2:0] OP_WI   = 3'b011;   // Write inverted
        localparam logic [2:0] OP_RT   = 3'b100;   // Read true
        localparam logic [2:0] OP_RI   = 3'b101;   // Read inverted

        // March element {ascending, two ops, op0, op1}
        localparam logic [7:0] MARCH_E0 = {1'b1, 1'b0, OP_WT, OP_NONE};
        localparam logic [7:0] MARCH_E1 = {1'b1, 1'b1, OP_RT, OP_WI};
        localparam logic [7:0] MARCH_E2 = {1'b0, 1'b1, OP_RI, OP_WT};
        localparam logic [7:0] MARCH_E3 = {1'b0, 1'b0, OP_RT, OP_NONE};

        typedef enum logic [2:0] {IDLE, CMD, CMP, NEXT, DONE} fsm_state_t;

endpackage

`default_nettype wire

/* src/mbist_seq_if.sv */
// Sequencing strobes and status between the MBIST control blocks
// Single clock domain, all strobes are one cycle wide
`timescale 1ns/1ns
`default_nettype none

interface mbist_seq_if;
        logic cmd_phase, cmp_phase;              // FSM phases
        logic run_op, run_addr, run_pat, start;  // Advance strobes
        logic op_read, op_write, op_invert;      // Current operation
        logic op_updown;                         // 1 = ascending
        logic last_op, last_elem, last_pat, last_addr;

        modport ctrl (output cmd_phase, cmp_phase, run_op, run_addr, run_pat, start,
                      input  op_read, last_op, last_addr, last_elem, last_pat);

        modport march (input  cmd_phase, run_op, run_addr, run_pat, start, last_addr,
                       output op_read, op_write, op_invert, op_updown,
                              last_op, last_elem, last_pat);

        modport addr (input run_addr, run_pat, start, op_updown, output last_addr);

        modport cmp (input cmp_phase, op_read, op_invert, run_addr);
endinterface

`default_nettype wire

/* src/mbist_fsm.sv */
// Main MBIST control FSM with four-phase req/ack handshake
// Dropping bist_req_i or bist_en_i before ack aborts the run
`timescale 1ns/1ns
`default_nettype none

module mbist_fsm (
        input  logic      wb_clk_i,
        input  logic      reset_i,
        input  logic      bist_req_i,
        input  logic      bist_en_i,
        output logic      bist_ack_o,
        mbist_seq_if.ctrl seq
);
        mbist_pkg::fsm_state_t state_q, state_d;
        logic run_ok;
        logic in_next;

        assign run_ok  = bist_req_i & bist_en_i;
        assign in_next = (state_q == mbist_pkg::NEXT);

        assign seq.start     = (state_q == mbist_pkg::IDLE) & run_ok;
        assign seq.cmd_phase = (state_q == mbist_pkg::CMD);
        assign seq.cmp_phase = (state_q == mbist_pkg::CMP);

        // One advance strobe per NEXT cycle
        assign seq.run_op   = in_next & ~seq.last_op;
        assign seq.run_addr = in_next & seq.last_op & (~seq.last_addr | ~seq.last_elem);
        assign seq.run_pat  = in_next & seq.last_op & seq.last_addr & seq.last_elem &
                              ~seq.last_pat;

        assign bist_ack_o = (state_q == mbist_pkg::DONE);

        always_comb begin
                state_d = state_q;
                case (state_q)
                mbist_pkg::IDLE: if (run_ok) state_d = mbist_pkg::CMD;
                mbist_pkg::CMD: begin
                        if (!run_ok)          state_d = mbist_pkg::IDLE;
                        else if (seq.op_read) state_d = mbist_pkg::CMP;   // Data back next cycle
                        else                  state_d = mbist_pkg::NEXT;
                end
                mbist_pkg::CMP: state_d = run_ok ? mbist_pkg::NEXT : mbist_pkg::IDLE;
                mbist_pkg::NEXT: begin
                        if (!run_ok)
                                state_d = mbist_pkg::IDLE;
                        else if (seq.last_op && seq.last_addr && seq.last_elem && seq.last_pat)
                                state_d = mbist_pkg::DONE;
                        else
                                state_d = mbist_pkg::CMD;
                end
                // Hold ack until the request drops
                mbist_pkg::DONE: if (!bist_req_i) state_d = mbist_pkg::IDLE;
                default: state_d = mbist_pkg::IDLE;
                endcase
        end

        always_ff @(posedge wb_clk_i) begin
                if (reset_i) state_q <= mbist_pkg::IDLE;
                else         state_q <= state_d;
        end

endmodule

`default_nettype wire

/* src/mbist_addr_gen.sv */
// Up/down address counter over the fixed test window
// Direction comes from the current march element
`timescale 1ns/1ns
`default_nettype none

module mbist_addr_gen (
        input  logic             wb_clk_i,
        input  logic             reset_i,
        mbist_seq_if.addr        seq,
        output mbist_pkg::addr_t bist_addr_o
);
        mbist_pkg::addr_t addr_q;
        mbist_pkg::addr_t start_addr, end_addr;
        logic             first_q;   // Element start, address follows direction

        assign start_addr = seq.op_updown ? mbist_pkg::ADDR_START : mbist_pkg::ADDR_END;
        assign end_addr   = seq.op_updown ? mbist_pkg::ADDR_END : mbist_pkg::ADDR_START;

        assign bist_addr_o   = first_q ? start_addr : addr_q;
        assign seq.last_addr = (bist_addr_o == end_addr);

        always_ff @(posedge wb_clk_i) begin
                if (reset_i || seq.start || seq.run_pat) begin
                        first_q <= 1'b1;
                        addr_q  <= mbist_pkg::ADDR_START;
                end else if (seq.run_addr) begin
                        first_q <= seq.last_addr;   // Reload for next element
                        addr_q  <= seq.op_updown ? bist_addr_o + 1'b1 : bist_addr_o - 1'b1;
                end
        end

endmodule

`default_nettype wire

/* src/mbist_march_sel.sv */
// March sequencer: element, op step and pattern tracking plus command forming
// The march table and patterns are fixed in the package
`timescale 1ns/1ns
`default_nettype none

module mbist_march_sel (
        input  logic             wb_clk_i,
        input  logic             reset_i,
        mbist_seq_if.march       seq,
        output logic             bist_wr_o,
        output logic             bist_rd_o,
        output mbist_pkg::data_t bist_wdata_o,
        output mbist_pkg::data_t exp_data_o
);
        localparam int PAT_IW = $clog2(mbist_pkg::NUM_PAT);

        mbist_pkg::elem_t    elem_q;
        logic                step_q;    // Second op of element
        logic [PAT_IW-1:0]   pat_q;
        logic [7:0]          entry;
        logic [2:0]          op;

        // ------------------------------------------------------------
        // Table decode
        always_comb begin
                case (elem_q)
                2'd0:    entry = mbist_pkg::MARCH_E0;
                2'd1:    entry = mbist_pkg::MARCH_E1;
                2'd2:    entry = mbist_pkg::MARCH_E2;
                default: entry = mbist_pkg::MARCH_E3;
                endcase
        end

        assign op            = step_q ? entry[2:0] : entry[5:3];
        assign seq.op_read   = op[2];
        assign seq.op_write  = op[1];
        assign seq.op_invert = op[0];
        assign seq.op_updown = entry[7];
        assign seq.last_op   = step_q | ~entry[6];
        assign seq.last_elem = (elem_q == mbist_pkg::elem_t'(mbist_pkg::NUM_ELEM - 1));
        assign seq.last_pat  = (pat_q == PAT_IW'(mbist_pkg::NUM_PAT - 1));

        // Commands only during the FSM command phase
        assign bist_wr_o    = seq.cmd_phase & seq.op_write;
        assign bist_rd_o    = seq.cmd_phase & seq.op_read;
        assign exp_data_o   = mbist_pkg::PAT_TABLE[pat_q];
        assign bist_wdata_o = seq.op_invert ? ~exp_data_o : exp_data_o;

        // ------------------------------------------------------------
        // Sequence counters
        always_ff @(posedge wb_clk_i) begin
                if (reset_i || seq.start) begin
                        elem_q <= '0;
                        step_q <= 1'b0;
                        pat_q  <= '0;
                end else if (seq.run_op) begin
                        step_q <= 1'b1;
                end else if (seq.run_addr) begin
                        step_q <= 1'b0;
                        if (seq.last_addr) elem_q <= elem_q + 2'd1;   // Next element
                end else if (seq.run_pat) begin
                        step_q <= 1'b0;
                        elem_q <= '0;
                        pat_q  <= pat_q + 1'b1;
                end
        end

endmodule

`default_nettype wire

/* src/mbist_data_cmp.sv */
// Read data comparator with saturating error count and first fail address
// Results stay valid until the next start strobe
`timescale 1ns/1ns
`default_nettype none

module mbist_data_cmp (
        input  logic                wb_clk_i,
        input  logic                reset_i,
        input  logic                start_i,
        mbist_seq_if.cmp            seq,
        input  mbist_pkg::data_t    exp_data_i,
        input  mbist_pkg::data_t    rdata_i,
        input  mbist_pkg::addr_t    addr_i,
        output logic                error_o,
        output mbist_pkg::err_cnt_t err_cnt_o,
        output mbist_pkg::addr_t    err_addr_o
);
        logic mismatch;
        logic visit_fail_q;   // Address already counted in this visit

        assign mismatch = seq.cmp_phase & seq.op_read &
                          (rdata_i != (seq.op_invert ? ~exp_data_i : exp_data_i));

        always_ff @(posedge wb_clk_i) begin
                if (reset_i || start_i) begin
                        error_o      <= 1'b0;
                        err_cnt_o    <= '0;
                        err_addr_o   <= '0;
                        visit_fail_q <= 1'b0;
                end else begin
                        if (seq.run_addr) visit_fail_q <= 1'b0;
                        if (mismatch) begin
                                error_o      <= 1'b1;   // Sticky
                                visit_fail_q <= 1'b1;
                                if (!visit_fail_q && err_cnt_o != '1)
                                        err_cnt_o <= err_cnt_o + 1'b1;
                                if (!error_o) err_addr_o <= addr_i;
                        end
                end
        end

endmodule

`default_nettype wire

/* src/mbist_mux.sv */
// SRAM port select between BIST and functional side
// Purely combinational, enables and write strobe are active low
`timescale 1ns/1ns
`default_nettype none

module mbist_mux (
        input  logic             bist_en_i,
        input  logic             bist_wr_i,
        input  logic             bist_rd_i,
        input  mbist_pkg::addr_t bist_addr_i,
        input  mbist_pkg::data_t bist_wdata_i,
        input  logic             func_cen_i,
        input  logic             func_web_i,
        input  mbist_pkg::mask_t func_mask_i,
        input  mbist_pkg::addr_t func_addr_i,
        input  mbist_pkg::data_t func_wdata_i,
        output logic             mem_cen_o,
        output logic             mem_web_o,
        output mbist_pkg::mask_t mem_mask_o,
        output mbist_pkg::addr_t mem_addr_o,
        output mbist_pkg::data_t mem_din_o
);
        // Idle BIST keeps the SRAM deselected
        assign mem_cen_o  = bist_en_i ? ~(bist_wr_i | bist_rd_i) : func_cen_i;
        assign mem_web_o  = bist_en_i ? ~bist_wr_i : func_web_i;
        assign mem_mask_o = bist_en_i ? '1 : func_mask_i;   // Full word writes
        assign mem_addr_o = bist_en_i ? bist_addr_i : func_addr_i;
        assign mem_din_o  = bist_en_i ? bist_wdata_i : func_wdata_i;

endmodule

`default_nettype wire

/* src/mbist_top.sv */
// MBIST controller for one single-port SRAM with functional bypass
// Functional port shares wb_clk_i, SRAM read latency is one cycle
`timescale 1ns/1ns
`default_nettype none

module mbist_top (
        input  logic                wb_clk_i,
        input  logic                reset_i,
        input  logic                bist_en_i,
        input  logic                bist_req_i,
        output logic                bist_ack_o,
        output logic                bist_error_o,
        output mbist_pkg::err_cnt_t bist_err_cnt_o,
        output mbist_pkg::addr_t    bist_err_addr_o,
        input  logic                func_cen_i,
        input  logic                func_web_i,
        input  mbist_pkg::mask_t    func_mask_i,
        input  mbist_pkg::addr_t    func_addr_i,
        input  mbist_pkg::data_t    func_wdata_i,
        output mbist_pkg::data_t    func_rdata_o,
        output logic                mem_cen_o,
        output logic                mem_web_o,
        output mbist_pkg::mask_t    mem_mask_o,
        output mbist_pkg::addr_t    mem_addr_o,
        output mbist_pkg::data_t    mem_din_o,
        input  mbist_pkg::data_t    mem_dout_i
);
        mbist_pkg::addr_t bist_addr;
        mbist_pkg::data_t bist_wdata;
        mbist_pkg::data_t exp_data;   // Current background pattern
        logic             bist_wr;
        logic             bist_rd;

        mbist_seq_if seq_if ();

        assign func_rdata_o = mem_dout_i;

        // ------------------------------------------------------------
        mbist_fsm u_fsm (
                .wb_clk_i   (wb_clk_i),
                .reset_i    (reset_i),
                .bist_req_i (bist_req_i),
                .bist_en_i  (bist_en_i),
                .bist_ack_o (bist_ack_o),
                .seq        (seq_if.ctrl)
        );

        mbist_addr_gen u_addr_gen (
                .wb_clk_i    (wb_clk_i),
                .reset_i     (reset_i),
                .seq         (seq_if.addr),
                .bist_addr_o (bist_addr)
        );

        mbist_march_sel u_march_sel (
                .wb_clk_i     (wb_clk_i),
                .reset_i      (reset_i),
                .seq          (seq_if.march),
                .bist_wr_o    (bist_wr),
                .bist_rd_o    (bist_rd),
                .bist_wdata_o (bist_wdata),
                .exp_data_o   (exp_data)
        );

        mbist_data_cmp u_cmp (
                .wb_clk_i   (wb_clk_i),
                .reset_i    (reset_i),
                .start_i    (seq_if.start),   // Clears results on new request
                .seq        (seq_if.cmp),
                .exp_data_i (exp_data),
                .rdata_i    (mem_dout_i),
                .addr_i     (bist_addr),
                .error_o    (bist_error_o),
                .err_cnt_o  (bist_err_cnt_o),
                .err_addr_o (bist_err_addr_o)
        );

        mbist_mux u_mem_sel (
                .bist_en_i    (bist_en_i),
                .bist_wr_i    (bist_wr),
                .bist_rd_i    (bist_rd),
                .bist_addr_i  (bist_addr),
                .bist_wdata_i (bist_wdata),
                .func_cen_i   (func_cen_i),
                .func_web_i   (func_web_i),
                .func_mask_i  (func_mask_i),
                .func_addr_i  (func_addr_i),
                .func_wdata_i (func_wdata_i),
                .mem_cen_o    (mem_cen_o),
                .mem_web_o    (mem_web_o),
                .mem_mask_o   (mem_mask_o),
                .mem_addr_o   (mem_addr_o),
                .mem_din_o    (mem_din_o)
        );

endmodule

`default_nettype wire

/* verif/mbist_checker.sv */
// Handshake and SRAM port assertions, bound into mbist_top
// Address window check applies only while BIST owns the SRAM
`timescale 1ns/1ns
`default_nettype none

module mbist_checker (
        input logic             wb_clk_i,
        input logic             reset_i,
        input logic             bist_en_i,
        input logic             bist_req_i,
        input logic             bist_ack_i,
        input logic             mem_cen_i,
        input logic             mem_web_i,
        input mbist_pkg::addr_t bist_addr_i
);
        // ------------------------------------------------------------
        ack_after_req: assert property (@(posedge wb_clk_i) disable iff (reset_i)
                $fell(bist_ack_i) |-> $past(!bist_req_i))
                else $error("bist_ack_o fell while bist_req_i was still high");

        web_needs_cen: assert property (@(posedge wb_clk_i) disable iff (reset_i)
                !mem_web_i |-> !mem_cen_i)
                else $error("mem_web_o low without mem_cen_o low");

        // Offset wraps for addresses below the start
        addr_in_window: assert property (@(posedge wb_clk_i) disable iff (reset_i)
                bist_en_i |-> ((bist_addr_i - mbist_pkg::ADDR_START) <=
                               (mbist_pkg::ADDR_END - mbist_pkg::ADDR_START)))
                else $error("BIST address 0x%h outside the test window", bist_addr_i);

endmodule

bind mbist_top mbist_checker u_checker (
        .wb_clk_i    (wb_clk_i),
        .reset_i     (reset_i),
        .bist_en_i   (bist_en_i),
        .bist_req_i  (bist_req_i),
        .bist_ack_i  (bist_ack_o),
        .mem_cen_i   (mem_cen_o),
        .mem_web_i   (mem_web_o),
        .bist_addr_i (bist_addr)
);

`default_nettype wire

/* verif/mbist_tb.sv */
// Testbench for mbist_top with a one-cycle SRAM model and stuck-at fault injection
// Faults act on reads only, BIST writes are always full words
`timescale 1ns/1ns
`default_nettype none

module mbist_tb;
        localparam int CLK_PERIOD = 10;
        localparam int LO         = int'(mbist_pkg::ADDR_START);
        localparam int HI         = int'(mbist_pkg::ADDR_END);
        localparam int WINDOW     = HI - LO + 1;

        logic                wb_clk_i = 1'b0;
        logic                reset_i, bist_en_i, bist_req_i;
        logic                bist_ack_o, bist_error_o;
        mbist_pkg::err_cnt_t bist_err_cnt_o;
        mbist_pkg::addr_t    bist_err_addr_o, func_addr_i, mem_addr_o;
        logic                func_cen_i, func_web_i, mem_cen_o, mem_web_o;
        mbist_pkg::mask_t    func_mask_i, mem_mask_o;
        mbist_pkg::data_t    func_wdata_i, func_rdata_o, mem_din_o;
        mbist_pkg::data_t    mem_dout = '0;
        mbist_pkg::data_t    mem [2**mbist_pkg::ADDR_WD];   // SRAM contents

        logic                fault_en, fault_val;
        int                  fault_addr, fault_bit;
        logic                exp_error;
        mbist_pkg::err_cnt_t exp_cnt;
        mbist_pkg::addr_t    exp_addr;
        int                  errors = 0;
        int                  result_errors = 0;   // From the ack compare process
        int                  runs = 0;
        logic                ack_q = 1'b0;
        logic [31:0]         rnd;
        mbist_pkg::data_t    wr_data [8];

        always #(CLK_PERIOD/2) wb_clk_i = ~wb_clk_i;

        mbist_top i_dut (
                .wb_clk_i (wb_clk_i), .reset_i (reset_i),
                .bist_en_i (bist_en_i), .bist_req_i (bist_req_i),
                .bist_ack_o (bist_ack_o), .bist_error_o (bist_error_o),
                .bist_err_cnt_o (bist_err_cnt_o), .bist_err_addr_o (bist_err_addr_o),
                .func_cen_i (func_cen_i), .func_web_i (func_web_i),
                .func_mask_i (func_mask_i), .func_addr_i (func_addr_i),
                .func_wdata_i (func_wdata_i), .func_rdata_o (func_rdata_o),
                .mem_cen_o (mem_cen_o), .mem_web_o (mem_web_o),
                .mem_mask_o (mem_mask_o), .mem_addr_o (mem_addr_o),
                .mem_din_o (mem_din_o), .mem_dout_i (mem_dout)
        );

        function automatic logic [31:0] xorshift(input logic [31:0] x);
                logic [31:0] y;
                y = x ^ (x << 13);
                y = y ^ (y >> 17);
                y = y ^ (y << 5);
                return y;
        endfunction

        function automatic logic [7:0] march_entry(input int e);
                case (e)
                0:       return mbist_pkg::MARCH_E0;
                1:       return mbist_pkg::MARCH_E1;
                2:       return mbist_pkg::MARCH_E2;
                default: return mbist_pkg::MARCH_E3;
                endcase
        endfunction

        // CMD and NEXT per op, plus CMP for a read
        function automatic int run_cycles();
                logic [7:0] entry;
                int         n;
                n = 0;
                for (int e = 0; e < mbist_pkg::NUM_ELEM; e++) begin
                        entry = march_entry(e);
                        n = n + WINDOW * (2 + int'(entry[5]));
                        if (entry[6]) n = n + WINDOW * (2 + int'(entry[2]));
                end
                return n * mbist_pkg::NUM_PAT;
        endfunction

        function automatic mbist_pkg::data_t faulty_read(input mbist_pkg::addr_t a);
                mbist_pkg::data_t w;
                w = mem[a];
                if (fault_en && int'(a) == fault_addr) w[fault_bit] = fault_val;
                return w;
        endfunction

        // ------------------------------------------------------------
        // Reference march walk in test order
        function automatic void march_ref(input logic f_en, input int f_addr,
                                          input int f_bit, input logic f_val,
                                          output logic err, output mbist_pkg::err_cnt_t cnt,
                                          output mbist_pkg::addr_t first);
                logic [7:0]       entry;
                logic [2:0]       op;
                mbist_pkg::data_t want;
                logic             bad;
                int               a;
                err   = 1'b0;
                cnt   = '0;
                first = '0;
                for (int p = 0; p < mbist_pkg::NUM_PAT; p++) begin
                        for (int e = 0; e < mbist_pkg::NUM_ELEM; e++) begin
                                entry = march_entry(e);
                                for (int i = 0; i < WINDOW; i++) begin
                                        a = entry[7] ? LO + i : HI - i;
                                        for (int s = 0; s <= int'(entry[6]); s++) begin
                                                op   = (s == 1) ? entry[2:0] : entry[5:3];
                                                want = op[0] ? ~mbist_pkg::PAT_TABLE[p]
                                                             : mbist_pkg::PAT_TABLE[p];
                                                // Stuck bit differs from the stored word
                                                bad  = op[2] && f_en && a == f_addr &&
                                                       want[f_bit] != f_val;
                                                if (bad && !err)
                                                        first = mbist_pkg::addr_t'(a);
                                                if (bad && cnt != '1)
                                                        cnt = cnt + mbist_pkg::err_cnt_t'(1);
                                                err = err | bad;
                                        end
                                end
                        end
                end
        endfunction

        // SRAM model, byte mask active high
        always @(posedge wb_clk_i) begin
                if (!mem_cen_o) begin
                        if (!mem_web_o) begin
                                for (int b = 0; b < mbist_pkg::MASK_WD; b++)
                                        if (mem_mask_o[b])
                                                mem[mem_addr_o][8*b +: 8] <= mem_din_o[8*b +: 8];
                        end else begin
                                mem_dout <= faulty_read(mem_addr_o);
                        end
                end
        end

        // Result compare on each rising ack
        always @(negedge wb_clk_i) begin
                if (!reset_i && bist_ack_o && !ack_q) begin
                        runs = runs + 1;
                        if (bist_error_o !== exp_error) begin
                                result_errors = result_errors + 1;
                                $display("Error: bist_error_o = 0x%h, expected 0x%h",
                                         bist_error_o, exp_error);
                        end
                        if (bist_err_cnt_o !== exp_cnt) begin
                                result_errors = result_errors + 1;
                                $display("Error: bist_err_cnt_o = 0x%h, expected 0x%h",
                                         bist_err_cnt_o, exp_cnt);
                        end
                        if (bist_err_addr_o !== exp_addr) begin
                                result_errors = result_errors + 1;
                                $display("Error: bist_err_addr_o = 0x%h, expected 0x%h",
                                         bist_err_addr_o, exp_addr);
                        end
                end
                ack_q = bist_ack_o;
        end

        task automatic run_bist();
                @(posedge wb_clk_i);
                #1 bist_req_i = 1'b1;
                @(posedge wb_clk_i);
                #1;
                if (bist_error_o !== 1'b0 || bist_err_cnt_o !== '0 ||
                    bist_err_addr_o !== '0) begin
                        errors = errors + 1;
                        $display("Failure: earlier results were not cleared by the new request");
                end
                while (bist_ack_o !== 1'b1) begin
                        @(posedge wb_clk_i);
                        #1;
                end
                repeat (3) begin   // Ack must hold while req is high
                        @(posedge wb_clk_i);
                        #1;
                        if (bist_ack_o !== 1'b1) begin
                                errors = errors + 1;
                                $display("Failure: bist_ack_o dropped while bist_req_i was high");
                        end
                end
                bist_req_i = 1'b0;
                @(posedge wb_clk_i);
                #1;
                if (bist_ack_o !== 1'b0) begin
                        errors = errors + 1;
                        $display("Failure: bist_ack_o did not fall after bist_req_i fell");
                end
        endtask

        // ------------------------------------------------------------
        initial begin
                reset_i      = 1'b1;
                bist_en_i    = 1'b1;
                bist_req_i   = 1'b0;
                func_cen_i   = 1'b1;
                func_web_i   = 1'b1;
                func_mask_i  = '1;
                func_addr_i  = '0;
                func_wdata_i = '0;
                fault_en     = 1'b0;
                fault_addr   = 0;
                fault_bit    = 0;
                fault_val    = 1'b0;
                rnd          = 32'd80;
                repeat (16) @(posedge wb_clk_i);
                #1 reset_i = 1'b0;
                if (bist_ack_o !== 1'b0) begin
                        errors = errors + 1;
                        $display("Error: bist_ack_o = 0x%h after reset, expected 0x0",
                                 bist_ack_o);
                end
                if (bist_error_o !== 1'b0) begin
                        errors = errors + 1;
                        $display("Error: bist_error_o = 0x%h after reset, expected 0x0",
                                 bist_error_o);
                end
                if (mem_cen_o !== 1'b1) begin
                        errors = errors + 1;
                        $display("Error: mem_cen_o = 0x%h after reset, expected 0x1",
                                 mem_cen_o);
                end

                march_ref(fault_en, fault_addr, fault_bit, fault_val,
                          exp_error, exp_cnt, exp_addr);
                run_bist();

                // One random stuck-at bit inside the window
                rnd        = xorshift(rnd);
                fault_addr = LO + int'(rnd % WINDOW);
                rnd        = xorshift(rnd);
                fault_bit  = int'(rnd[4:0]);
                rnd        = xorshift(rnd);
                fault_val  = rnd[0];
                fault_en   = 1'b1;
                $display("Stuck-at-%0d on bit %0d of address 0x%h",
                         fault_val, fault_bit, fault_addr);
                march_ref(fault_en, fault_addr, fault_bit, fault_val,
                          exp_error, exp_cnt, exp_addr);
                run_bist();

                fault_en = 1'b0;
                march_ref(fault_en, fault_addr, fault_bit, fault_val,
                          exp_error, exp_cnt, exp_addr);
                run_bist();

                // Functional port with BIST disabled
                bist_en_i = 1'b0;
                for (int i = 0; i < 8; i++) begin
                        rnd          = xorshift(rnd);
                        func_cen_i   = 1'b0;
                        func_web_i   = 1'b0;
                        func_mask_i  = rnd[31:28];
                        func_addr_i  = mbist_pkg::addr_t'(LO + 3 * i);
                        func_wdata_i = rnd;
                        // Masked bytes keep the last true pattern of the march
                        wr_data[i]   = mbist_pkg::PAT_TABLE[mbist_pkg::NUM_PAT - 1];
                        for (int b = 0; b < mbist_pkg::MASK_WD; b++)
                                if (func_mask_i[b]) wr_data[i][8*b +: 8] = rnd[8*b +: 8];
                        @(posedge wb_clk_i);
                        #1;
                end
                for (int i = 0; i < 8; i++) begin
                        func_cen_i  = 1'b0;
                        func_web_i  = 1'b1;
                        func_addr_i = mbist_pkg::addr_t'(LO + 3 * i);
                        @(posedge wb_clk_i);
                        #1;
                        if (func_rdata_o !== wr_data[i]) begin
                                errors = errors + 1;
                                $display("Error: func_rdata_o = 0x%h, expected 0x%h",
                                         func_rdata_o, wr_data[i]);
                        end
                end
                func_cen_i = 1'b1;
                func_web_i = 1'b1;

                if (runs != 3) begin
                        errors = errors + 1;
                        $display("Failure: only %0d of 3 BIST runs reached the result compare", runs);
                end
                errors = errors + result_errors;
                $display("Summary: %0d errors over %0d BIST runs", errors, runs);
                if (errors == 0)
                        $display("=== PASS ===");
                else
                        $display("=== FAIL ===");
                $finish;
        end

        // Watchdog sized from three full runs
        initial begin
                int limit;
                limit = 3 * run_cycles() + 2000;
                repeat (limit) @(posedge wb_clk_i);
                $display("Failure: simulation did not finish within %0d cycles", limit);
                $display("=== FAIL ===");
                $finish;
        end

endmodule

`default_nettype wire

/* sources.f */
src/mbist_pkg.sv
src/mbist_seq_if.sv
src/mbist_fsm.sv
src/mbist_addr_gen.sv
src/mbist_march_sel.sv
src/mbist_data_cmp.sv
src/mbist_mux.sv
src/mbist_top.sv
verif/mbist_checker.sv
verif/mbist_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := mbist_tb
FILELIST  := sources.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@grep -q "^=== PASS ===$$" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
